//--- tb.f
+incdir+verilog
verilog/eth_pkg.sv
verilog/eth_stream_if.sv
verilog/pkt_gate.sv
verilog/eth_dispatch.sv
verilog/switch_regs.sv
verilog/egress_mux.sv
verilog/eth_switch_top.sv
tests/eth_switch_assert.sv
tests/eth_checker.sv
tests/tb_eth_switch.sv

//--- tests/eth_checker.sv
// Switch scoreboard
// Models ingress classification, egress merging and the frame counters,
// and compares every output transfer and register read with the model
`include "eth_params.svh"

module eth_checker (
   input  logic               clk,
   input  logic               reset,
   input  logic               i_reg_wr_req,
   input  eth_pkg::reg_addr_t i_reg_wr_addr,
   input  eth_pkg::reg_data_t i_reg_wr_data,
   input  logic               i_reg_rd_req,
   input  eth_pkg::reg_addr_t i_reg_rd_addr,
   input  logic               o_reg_rd_resp,
   input  eth_pkg::reg_data_t o_reg_rd_data,
   input  eth_pkg::eth_data_t i_eth_rx_tdata, o_eth_tx_tdata, o_e2v_tdata, o_e2c_tdata,
   input  eth_pkg::eth_data_t i_v2e_tdata, i_c2e_tdata,
   input  eth_pkg::eth_user_t i_eth_rx_tuser, o_eth_tx_tuser, o_e2c_tuser, i_c2e_tuser,
   input  logic               i_eth_rx_tlast, i_eth_rx_tvalid, o_eth_rx_tready,
   input  logic               o_eth_tx_tlast, o_eth_tx_tvalid, i_eth_tx_tready,
   input  logic               o_e2v_tlast, o_e2v_tvalid, i_e2v_tready,
   input  logic               o_e2c_tlast, o_e2c_tvalid, i_e2c_tready,
   input  logic               i_v2e_tlast, i_v2e_tvalid, o_v2e_tready,
   input  logic               i_c2e_tlast, i_c2e_tvalid, o_c2e_tready,
   output int                 o_data_errs,
   output int                 o_reg_errs,
   output logic               o_idle
);
   timeunit 1ns;
   timeprecision 1ps;

   // Word layout is user, last, data
   typedef logic [68:0] word_t;

   word_t              rx_frame[$];
   word_t              exp_vita[$];
   word_t              exp_cpu[$];
   word_t              exp_v2e[$];
   word_t              exp_c2e[$];
   eth_pkg::udp_port_t my_port;
   eth_pkg::reg_addr_t rd_addr;
   logic               rd_pend;
   logic               tx_busy;
   logic               tx_src;
   int                 n_vita;
   int                 n_cpu;
   int                 n_drop;
   int                 data_errs = 0;
   int                 reg_errs = 0;

   assign o_data_errs = data_errs;
   assign o_reg_errs  = reg_errs;

   task automatic check_word(input string where, input word_t got, input int avail,
                             input word_t exp);
      if (avail == 0) begin
         data_errs++;
         $display("ERR %0t: %s sent unexpected word %h", $time, where, got);
      end else if (got !== exp) begin
         data_errs++;
         $display("ERR %0t: %s sent %h, expected %h", $time, where, got, exp);
      end
   endtask

   function automatic eth_pkg::reg_data_t reg_model(input eth_pkg::reg_addr_t a);
      case (a)
         `REG_MY_PORT:  return eth_pkg::reg_data_t'(my_port);
         `REG_CNT_VITA: return eth_pkg::reg_data_t'(n_vita);
         `REG_CNT_CPU:  return eth_pkg::reg_data_t'(n_cpu);
         `REG_CNT_DROP: return eth_pkg::reg_data_t'(n_drop);
         default:       return '0;
      endcase
   endfunction

   always @(posedge clk) begin
      word_t w;
      word_t e;
      int    n;
      if (reset) begin
         my_port <= `MY_PORT_RESET;
         rd_pend <= 1'b0;
         tx_busy <= 1'b0;
         o_idle  <= 1'b0;
         n_vita = 0;
         n_cpu  = 0;
         n_drop = 0;
      end else begin
         if (i_reg_wr_req && i_reg_wr_addr == `REG_MY_PORT) my_port <= i_reg_wr_data[15:0];

         // Ingress frames are classified once their last word is in
         if (i_eth_rx_tvalid && o_eth_rx_tready) begin
            rx_frame.push_back({i_eth_rx_tuser, i_eth_rx_tlast, i_eth_rx_tdata});
            if (i_eth_rx_tlast) begin
               if (i_eth_rx_tuser[3]) begin
                  n_drop++;
               end else if (rx_frame[0][15:0] == my_port) begin
                  n_vita++;
                  foreach (rx_frame[i]) exp_vita.push_back({4'h0, rx_frame[i][64:0]});
               end else begin
                  n_cpu++;
                  foreach (rx_frame[i]) exp_cpu.push_back(rx_frame[i]);
               end
               rx_frame.delete();
            end
         end
         if (i_v2e_tvalid && o_v2e_tready) exp_v2e.push_back({4'h0, i_v2e_tlast, i_v2e_tdata});
         if (i_c2e_tvalid && o_c2e_tready) begin
            exp_c2e.push_back({i_c2e_tuser, i_c2e_tlast, i_c2e_tdata});
         end

         ////////////////////////////////////////////////////////////
         // Output transfers
         ////////////////////////////////////////////////////////////
         if (o_e2v_tvalid && i_e2v_tready) begin
            w = {4'h0, o_e2v_tlast, o_e2v_tdata};
            n = exp_vita.size();
            e = '0;
            if (n > 0) e = exp_vita.pop_front();
            check_word("stream output", w, n, e);
         end
         if (o_e2c_tvalid && i_e2c_tready) begin
            w = {o_e2c_tuser, o_e2c_tlast, o_e2c_tdata};
            n = exp_cpu.size();
            e = '0;
            if (n > 0) e = exp_cpu.pop_front();
            check_word("CPU output", w, n, e);
         end
         if (o_eth_tx_tvalid && i_eth_tx_tready) begin
            w = {o_eth_tx_tuser, o_eth_tx_tlast, o_eth_tx_tdata};
            // Data bit 63 tags the source and is 1 for the stream input
            if (tx_busy && w[63] != tx_src) begin
               data_errs++;
               $display("ERR %0t: transmit port switched source inside a frame", $time);
            end
            e = '0;
            if (w[63]) begin
               n = exp_v2e.size();
               if (n > 0) e = exp_v2e.pop_front();
            end else begin
               n = exp_c2e.size();
               if (n > 0) e = exp_c2e.pop_front();
            end
            check_word("transmit port", w, n, e);
            tx_busy <= !o_eth_tx_tlast;
            tx_src  <= w[63];
         end

         // Read response is due exactly one cycle after the request
         rd_pend <= i_reg_rd_req;
         rd_addr <= i_reg_rd_addr;
         if (o_reg_rd_resp !== rd_pend) begin
            reg_errs++;
            $display("ERR %0t: read response %b, expected %b", $time, o_reg_rd_resp, rd_pend);
         end else if (rd_pend && o_reg_rd_data !== reg_model(rd_addr)) begin
            reg_errs++;
            $display("ERR %0t: register %0d read %h, expected %h", $time, rd_addr,
                     o_reg_rd_data, reg_model(rd_addr));
         end
         o_idle <= (rx_frame.size() == 0) && (exp_vita.size() == 0) &&
                   (exp_cpu.size() == 0) && (exp_v2e.size() == 0) && (exp_c2e.size() == 0);
      end
   end

endmodule

//--- tests/eth_switch_assert.sv
// Switch port protocol checks
// Quiet outputs around reset and stable words on stalled outputs

module eth_switch_assert (
   input logic               clk,
   input logic               reset,
   input logic               o_reg_rd_resp,
   input eth_pkg::eth_data_t o_eth_tx_tdata,
   input logic               o_eth_tx_tlast,
   input logic               o_eth_tx_tvalid,
   input logic               i_eth_tx_tready,
   input eth_pkg::eth_data_t o_e2v_tdata,
   input logic               o_e2v_tlast,
   input logic               o_e2v_tvalid,
   input logic               i_e2v_tready,
   input eth_pkg::eth_data_t o_e2c_tdata,
   input logic               o_e2c_tlast,
   input logic               o_e2c_tvalid,
   input logic               i_e2c_tready
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;

   // Nothing may be offered in the cycle after a reset edge
   a_reset_quiet: assert property (@(posedge clk) $past(reset) |->
         !(o_eth_tx_tvalid || o_e2v_tvalid || o_e2c_tvalid || o_reg_rd_resp))
      else begin
         $error("valid output high during or just after reset");
         fail_cnt++;
      end

   ////////////////////////////////////////////////////////////
   // Stalled outputs hold their word
   ////////////////////////////////////////////////////////////

   a_tx_hold: assert property (@(posedge clk) disable iff (reset)
         o_eth_tx_tvalid && !i_eth_tx_tready |=>
         o_eth_tx_tvalid && $stable(o_eth_tx_tdata) && $stable(o_eth_tx_tlast))
      else begin
         $error("transmit word changed while stalled");
         fail_cnt++;
      end

   a_e2v_hold: assert property (@(posedge clk) disable iff (reset)
         o_e2v_tvalid && !i_e2v_tready |=>
         o_e2v_tvalid && $stable(o_e2v_tdata) && $stable(o_e2v_tlast))
      else begin
         $error("stream output word changed while stalled");
         fail_cnt++;
      end

   a_e2c_hold: assert property (@(posedge clk) disable iff (reset)
         o_e2c_tvalid && !i_e2c_tready |=>
         o_e2c_tvalid && $stable(o_e2c_tdata) && $stable(o_e2c_tlast))
      else begin
         $error("CPU output word changed while stalled");
         fail_cnt++;
      end

endmodule

bind eth_switch_top eth_switch_assert u_assert (.*);

//--- tests/tb_eth_switch.sv
// Switch testbench
// Random frames on all inputs with random back-pressure, the port register
// reprogrammed between two traffic phases, and a final register check
`include "eth_params.svh"

module tb_eth_switch;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_RX = 60;
   localparam int N_EG = 30;
   // Worst case words over both phases at 16 words per frame
   localparam int MAX_WORDS = 2 * (N_RX + 2 * N_EG) * 16;
   localparam int TIMEOUT_CYCLES = MAX_WORDS * 40 + 1000;

   logic               clk;
   logic               reset;
   logic               i_reg_wr_req, i_reg_rd_req, o_reg_rd_resp;
   eth_pkg::reg_addr_t i_reg_wr_addr, i_reg_rd_addr;
   eth_pkg::reg_data_t i_reg_wr_data, o_reg_rd_data;
   eth_pkg::eth_data_t i_eth_rx_tdata, o_eth_tx_tdata, o_e2v_tdata, o_e2c_tdata;
   eth_pkg::eth_data_t i_v2e_tdata, i_c2e_tdata;
   eth_pkg::eth_user_t i_eth_rx_tuser, o_eth_tx_tuser, o_e2c_tuser, i_c2e_tuser;
   logic               i_eth_rx_tlast, i_eth_rx_tvalid, o_eth_rx_tready;
   logic               o_eth_tx_tlast, o_eth_tx_tvalid, i_eth_tx_tready;
   logic               o_e2v_tlast, o_e2v_tvalid, i_e2v_tready;
   logic               o_e2c_tlast, o_e2c_tvalid, i_e2c_tready;
   logic               i_v2e_tlast, i_v2e_tvalid, o_v2e_tready;
   logic               i_c2e_tlast, i_c2e_tvalid, o_c2e_tready;

   logic [31:0]        lfsr;
   eth_pkg::udp_port_t cur_port;
   int                 data_errs;
   int                 reg_errs;
   logic               chk_idle;

   eth_switch_top uut (.*);

   eth_checker u_checker (
      .*, .o_data_errs(data_errs), .o_reg_errs(reg_errs), .o_idle(chk_idle)
   );

   always #50 clk = ~clk;

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[62:0], fb};
      end
      return r;
   endfunction

   // Outputs ready about three cycles in four
   always @(negedge clk) begin
      i_eth_tx_tready = (rand_bits(2) != 0);
      i_e2v_tready    = (rand_bits(2) != 0);
      i_e2c_tready    = (rand_bits(2) != 0);
   end

   ////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////

   task automatic send_rx(input int len, input logic err, input logic match);
      logic [63:0] d;
      for (int w = 0; w < len; w++) begin
         d = rand_bits(64);
         if (w == 0 && match) d[15:0] = cur_port;
         i_eth_rx_tdata  = d;
         i_eth_rx_tuser  = {err && (w == len - 1), 3'(rand_bits(3))};
         i_eth_rx_tlast  = (w == len - 1);
         i_eth_rx_tvalid = 1'b1;
         do @(posedge clk); while (!o_eth_rx_tready);
         @(negedge clk);
      end
      i_eth_rx_tvalid = 1'b0;
      repeat (int'(rand_bits(2))) @(negedge clk);
   endtask

   task automatic send_egress(input logic cpu, input int len);
      logic [63:0] d;
      for (int w = 0; w < len; w++) begin
         d = rand_bits(64);
         d[63] = !cpu;
         if (cpu) begin
            i_c2e_tdata  = d;
            i_c2e_tuser  = 4'(rand_bits(3));
            i_c2e_tlast  = (w == len - 1);
            i_c2e_tvalid = 1'b1;
            do @(posedge clk); while (!o_c2e_tready);
         end else begin
            i_v2e_tdata  = d;
            i_v2e_tlast  = (w == len - 1);
            i_v2e_tvalid = 1'b1;
            do @(posedge clk); while (!o_v2e_tready);
         end
         @(negedge clk);
      end
      if (cpu) i_c2e_tvalid = 1'b0;
      else i_v2e_tvalid = 1'b0;
      repeat (int'(rand_bits(2))) @(negedge clk);
   endtask

   // About a quarter of ingress frames errored and half aimed at the programmed port
   task automatic run_phase();
      fork
         for (int i = 0; i < N_RX; i++) begin
            send_rx(1 + int'(rand_bits(4)), rand_bits(2) == 0, rand_bits(1) != 0);
         end
         for (int i = 0; i < N_EG; i++) send_egress(1'b0, 1 + int'(rand_bits(4)));
         for (int i = 0; i < N_EG; i++) send_egress(1'b1, 1 + int'(rand_bits(4)));
      join
   endtask

   task automatic wait_idle();
      do @(posedge clk); while (!chk_idle);
      repeat (4) @(negedge clk);
   endtask

   task automatic reg_write(input eth_pkg::reg_addr_t a, input eth_pkg::reg_data_t d);
      @(negedge clk);
      i_reg_wr_req  = 1'b1;
      i_reg_wr_addr = a;
      i_reg_wr_data = d;
      @(negedge clk);
      i_reg_wr_req = 1'b0;
   endtask

   task automatic reg_read(input eth_pkg::reg_addr_t a);
      @(negedge clk);
      i_reg_rd_req  = 1'b1;
      i_reg_rd_addr = a;
      @(negedge clk);
      i_reg_rd_req = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      clk      = 1'b0;
      reset    = 1'b1;
      lfsr     = 32'h2c18;
      cur_port = `MY_PORT_RESET;
      i_reg_wr_req = 1'b0;
      i_reg_wr_addr = '0;
      i_reg_wr_data = '0;
      i_reg_rd_req = 1'b0;
      i_reg_rd_addr = '0;
      i_eth_rx_tdata = '0;
      i_eth_rx_tuser = '0;
      i_eth_rx_tlast = 1'b0;
      i_eth_rx_tvalid = 1'b0;
      i_v2e_tdata = '0;
      i_v2e_tlast = 1'b0;
      i_v2e_tvalid = 1'b0;
      i_c2e_tdata = '0;
      i_c2e_tuser = '0;
      i_c2e_tlast = 1'b0;
      i_c2e_tvalid = 1'b0;
      i_eth_tx_tready = 1'b0;
      i_e2v_tready = 1'b0;
      i_e2c_tready = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      reg_read(`REG_MY_PORT);
      run_phase();
      wait_idle();
      // Reprogram the port while the gate is empty
      cur_port = 16'(rand_bits(16));
      reg_write(`REG_MY_PORT, eth_pkg::reg_data_t'(cur_port));
      run_phase();
      wait_idle();
      reg_read(`REG_MY_PORT);
      reg_read(`REG_CNT_VITA);
      reg_read(`REG_CNT_CPU);
      reg_read(`REG_CNT_DROP);
      reg_read(4'h9);
      repeat (4) @(negedge clk);

      $display("Errors: data %0d, register %0d, assertion %0d",
               data_errs, reg_errs, uut.u_assert.fail_cnt);
      if (data_errs + reg_errs + uut.u_assert.fail_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: traffic did not drain within %0d clock cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- verilog/egress_mux.sv
// Egress frame arbiter
// Round-robin merge of the CPU and stream inputs onto the MAC transmit
// stream, never switching inside a frame

module egress_mux (
   input  logic      clk,
   input  logic      reset,
   eth_stream_if.snk in0,
   eth_stream_if.snk in1,
   eth_stream_if.src out
);

   logic locked;
   logic grant;
   logic last_win;
   logic pick;
   logic sel;

   // Idle choice favours the input that did not win last time
   always_comb begin
      if (last_win == 1'b0 && in1.tvalid) begin
         pick = 1'b1;
      end else if (last_win == 1'b1 && in0.tvalid) begin
         pick = 1'b0;
      end else begin
         pick = !in0.tvalid && in1.tvalid;
      end
   end

   assign sel = locked ? grant : pick;

   ////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////

   assign out.tdata  = sel ? in1.tdata  : in0.tdata;
   assign out.tuser  = sel ? in1.tuser  : in0.tuser;
   assign out.tlast  = sel ? in1.tlast  : in0.tlast;
   assign out.tvalid = sel ? in1.tvalid : in0.tvalid;
   assign in0.tready = !sel && out.tready;
   assign in1.tready = sel && out.tready;

   // Lock as soon as a word is offered so a stalled word stays put
   always_ff @(posedge clk) begin
      if (reset) begin
         locked   <= 1'b0;
         grant    <= 1'b0;
         last_win <= 1'b0;
      end else if (out.tvalid) begin
         if (out.tready && out.tlast) begin
            locked   <= 1'b0;
            last_win <= sel;
         end else begin
            locked <= 1'b1;
            grant  <= sel;
         end
      end
   end

endmodule

//--- verilog/eth_dispatch.sv
// Ingress frame dispatcher
// Classifies a frame by the UDP destination port in its first word and
// steers every word of that frame to the stream or the CPU output.

module eth_dispatch (
   input  logic                 clk,
   input  logic                 reset,
   eth_stream_if.snk            in,
   input  eth_pkg::udp_port_t   i_my_port,
   eth_stream_if.src            vita,
   eth_stream_if.src            cpu,
   output logic                 o_fwd_vita,
   output logic                 o_fwd_cpu
);

   eth_pkg::dispatch_state_t state;
   logic                     port_match;
   logic                     sel_vita;
   logic                     sel_cpu;
   logic                     in_xfer;

   // Low 16 bits of the first word hold the UDP destination port
   assign port_match = (in.tdata[15:0] == i_my_port);

   assign sel_vita = (state == eth_pkg::TO_VITA) ||
                     ((state == eth_pkg::IDLE) && port_match);
   assign sel_cpu  = (state == eth_pkg::TO_CPU) ||
                     ((state == eth_pkg::IDLE) && !port_match);

   ////////////////////////////////////////////////////////////
   // Output steering
   ////////////////////////////////////////////////////////////

   assign vita.tdata  = in.tdata;
   assign vita.tuser  = '0;
   assign vita.tlast  = in.tlast;
   assign vita.tvalid = in.tvalid && sel_vita;

   assign cpu.tdata   = in.tdata;
   assign cpu.tuser   = in.tuser;
   assign cpu.tlast   = in.tlast;
   assign cpu.tvalid  = in.tvalid && sel_cpu;

   // Unselected output never stalls the gate
   assign in.tready = sel_vita ? vita.tready : cpu.tready;
   assign in_xfer   = in.tvalid && in.tready;

   // First-word strobes for the frame counters
   assign o_fwd_vita = in_xfer && (state == eth_pkg::IDLE) && port_match;
   assign o_fwd_cpu  = in_xfer && (state == eth_pkg::IDLE) && !port_match;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= eth_pkg::IDLE;
      end else if (in_xfer) begin
         case (state)
            eth_pkg::IDLE: begin
               // Single-word frames stay in IDLE
               if (!in.tlast) begin
                  state <= port_match ? eth_pkg::TO_VITA : eth_pkg::TO_CPU;
               end
            end
            eth_pkg::TO_VITA,
            eth_pkg::TO_CPU: begin
               if (in.tlast) begin
                  state <= eth_pkg::IDLE;
               end
            end
            default: begin
               state <= eth_pkg::IDLE;
            end
         endcase
      end
   end

endmodule

//--- verilog/eth_params.svh
// Ethernet switch core parameters
// Stream widths, gate depth and register map
`ifndef ETH_PARAMS_SVH
`define ETH_PARAMS_SVH

`define ETH_DWIDTH       64
// Bit 3 of the user field is the error flag
`define ETH_UWIDTH       4
`define ETH_GATE_AWIDTH  6

`define REG_AWIDTH       4
`define REG_DWIDTH       32

`define REG_MY_PORT      0
`define REG_CNT_VITA     1
`define REG_CNT_CPU      2
`define REG_CNT_DROP     3

`define MY_PORT_RESET    16'h0bad

`endif

//--- verilog/eth_pkg.sv
// Ethernet switch core types
// Vector typedefs shared by the blocks and the dispatcher state encoding
`include "eth_params.svh"

package eth_pkg;

   typedef logic [`ETH_DWIDTH-1:0] eth_data_t;
   typedef logic [`ETH_UWIDTH-1:0] eth_user_t;
   typedef logic [15:0]            udp_port_t;

   typedef logic [`REG_AWIDTH-1:0] reg_addr_t;
   typedef logic [`REG_DWIDTH-1:0] reg_data_t;
   typedef logic [31:0]            frame_cnt_t;

   // Dispatcher routing state held from first word to tlast
   typedef enum logic [1:0] {
      IDLE,
      TO_VITA,
      TO_CPU
   } dispatch_state_t;

endpackage

//--- verilog/eth_stream_if.sv
// Packet stream bundle
// Valid/ready handshake with a last-word flag and a user sideband

interface eth_stream_if;

   eth_pkg::eth_data_t tdata;
   eth_pkg::eth_user_t tuser;
   logic               tlast;
   logic               tvalid;
   logic               tready;

   // Driving side
   modport src (
      output tdata, tuser, tlast, tvalid,
      input  tready
   );

   // Receiving side
   modport snk (
      input  tdata, tuser, tlast, tvalid,
      output tready
   );

endinterface

//--- verilog/eth_switch_top.sv
// Ethernet switch core
// Ingress gate and dispatcher toward the stream and CPU outputs,
// egress arbiter toward the MAC, and the control registers
`include "eth_params.svh"

module eth_switch_top (
   input  logic                clk,
   input  logic                reset,
   // Register port
   input  logic                i_reg_wr_req,
   input  eth_pkg::reg_addr_t  i_reg_wr_addr,
   input  eth_pkg::reg_data_t  i_reg_wr_data,
   input  logic                i_reg_rd_req,
   input  eth_pkg::reg_addr_t  i_reg_rd_addr,
   output logic                o_reg_rd_resp,
   output eth_pkg::reg_data_t  o_reg_rd_data,
   // MAC receive
   input  eth_pkg::eth_data_t  i_eth_rx_tdata,
   input  eth_pkg::eth_user_t  i_eth_rx_tuser,
   input  logic                i_eth_rx_tlast,
   input  logic                i_eth_rx_tvalid,
   output logic                o_eth_rx_tready,
   // MAC transmit
   output eth_pkg::eth_data_t  o_eth_tx_tdata,
   output eth_pkg::eth_user_t  o_eth_tx_tuser,
   output logic                o_eth_tx_tlast,
   output logic                o_eth_tx_tvalid,
   input  logic                i_eth_tx_tready,
   // To the stream router
   output eth_pkg::eth_data_t  o_e2v_tdata,
   output logic                o_e2v_tlast,
   output logic                o_e2v_tvalid,
   input  logic                i_e2v_tready,
   // To the CPU
   output eth_pkg::eth_data_t  o_e2c_tdata,
   output eth_pkg::eth_user_t  o_e2c_tuser,
   output logic                o_e2c_tlast,
   output logic                o_e2c_tvalid,
   input  logic                i_e2c_tready,
   // From the stream router
   input  eth_pkg::eth_data_t  i_v2e_tdata,
   input  logic                i_v2e_tlast,
   input  logic                i_v2e_tvalid,
   output logic                o_v2e_tready,
   // From the CPU
   input  eth_pkg::eth_data_t  i_c2e_tdata,
   input  eth_pkg::eth_user_t  i_c2e_tuser,
   input  logic                i_c2e_tlast,
   input  logic                i_c2e_tvalid,
   output logic                o_c2e_tready
);

   eth_stream_if rx ();
   eth_stream_if gated ();
   eth_stream_if to_vita ();
   eth_stream_if to_cpu ();
   eth_stream_if from_vita ();
   eth_stream_if from_cpu ();
   eth_stream_if tx ();

   eth_pkg::udp_port_t my_port;
   logic               drop;
   logic               fwd_vita;
   logic               fwd_cpu;

   ////////////////////////////////////////////////////////////
   // Port mapping
   ////////////////////////////////////////////////////////////

   assign rx.tdata  = i_eth_rx_tdata;
   assign rx.tuser  = i_eth_rx_tuser;
   assign rx.tlast  = i_eth_rx_tlast;
   assign rx.tvalid = i_eth_rx_tvalid;
   assign o_eth_rx_tready = rx.tready;

   assign o_e2v_tdata  = to_vita.tdata;
   assign o_e2v_tlast  = to_vita.tlast;
   assign o_e2v_tvalid = to_vita.tvalid;
   assign to_vita.tready = i_e2v_tready;

   assign o_e2c_tdata  = to_cpu.tdata;
   assign o_e2c_tuser  = to_cpu.tuser;
   assign o_e2c_tlast  = to_cpu.tlast;
   assign o_e2c_tvalid = to_cpu.tvalid;
   assign to_cpu.tready = i_e2c_tready;

   // Stream router frames carry no sideband
   assign from_vita.tdata  = i_v2e_tdata;
   assign from_vita.tuser  = '0;
   assign from_vita.tlast  = i_v2e_tlast;
   assign from_vita.tvalid = i_v2e_tvalid;
   assign o_v2e_tready = from_vita.tready;

   assign from_cpu.tdata  = i_c2e_tdata;
   assign from_cpu.tuser  = i_c2e_tuser;
   assign from_cpu.tlast  = i_c2e_tlast;
   assign from_cpu.tvalid = i_c2e_tvalid;
   assign o_c2e_tready = from_cpu.tready;

   assign o_eth_tx_tdata  = tx.tdata;
   assign o_eth_tx_tuser  = tx.tuser;
   assign o_eth_tx_tlast  = tx.tlast;
   assign o_eth_tx_tvalid = tx.tvalid;
   assign tx.tready = i_eth_tx_tready;

   ////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////

   pkt_gate #(.AWIDTH(`ETH_GATE_AWIDTH)) u_gate (
      .clk(clk), .reset(reset),
      .in(rx), .out(gated), .o_drop(drop)
   );

   eth_dispatch u_dispatch (
      .clk(clk), .reset(reset),
      .in(gated), .i_my_port(my_port),
      .vita(to_vita), .cpu(to_cpu),
      .o_fwd_vita(fwd_vita), .o_fwd_cpu(fwd_cpu)
   );

   switch_regs u_regs (
      .clk(clk), .reset(reset),
      .i_reg_wr_req(i_reg_wr_req), .i_reg_wr_addr(i_reg_wr_addr),
      .i_reg_wr_data(i_reg_wr_data),
      .i_reg_rd_req(i_reg_rd_req), .i_reg_rd_addr(i_reg_rd_addr),
      .o_reg_rd_resp(o_reg_rd_resp), .o_reg_rd_data(o_reg_rd_data),
      .i_fwd_vita(fwd_vita), .i_fwd_cpu(fwd_cpu), .i_drop(drop),
      .o_my_port(my_port)
   );

   // Input 0 is the CPU, input 1 the stream router
   egress_mux u_egress (
      .clk(clk), .reset(reset),
      .in0(from_cpu), .in1(from_vita), .out(tx)
   );

endmodule

//--- verilog/pkt_gate.sv
// Whole-frame ingress gate
// Holds each frame in a circular buffer until its last word arrives.
// Frames whose last word has the error flag set are discarded in place.
`include "eth_params.svh"

module pkt_gate #(
   parameter int AWIDTH = `ETH_GATE_AWIDTH
) (
   input  logic      clk,
   input  logic      reset,
   eth_stream_if.snk in,
   eth_stream_if.src out,
   output logic      o_drop
);

   localparam int DW = $bits(eth_pkg::eth_data_t);
   localparam int UW = $bits(eth_pkg::eth_user_t);
   // Stored word is user, last, data
   localparam int MW = DW + UW + 1;

   // Pointers carry one extra bit to tell full from empty
   logic [AWIDTH:0] wr_ptr;
   logic [AWIDTH:0] commit_ptr;
   logic [AWIDTH:0] rd_ptr;
   logic [MW-1:0]   mem [0:(1<<AWIDTH)-1];
   logic [MW-1:0]   rd_word;
   logic            full;
   logic            in_xfer;
   logic            in_err;
   logic            out_xfer;

   ////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////

   assign full = (wr_ptr[AWIDTH] != rd_ptr[AWIDTH]) &&
                 (wr_ptr[AWIDTH-1:0] == rd_ptr[AWIDTH-1:0]);
   assign in.tready = !full;
   assign in_xfer = in.tvalid && in.tready;
   // Top user bit flags a bad frame from the MAC
   assign in_err = in.tuser[UW-1];

   always_ff @(posedge clk) begin
      if (in_xfer) begin
         mem[wr_ptr[AWIDTH-1:0]] <= {in.tuser, in.tlast, in.tdata};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         o_drop     <= 1'b0;
      end else begin
         o_drop <= 1'b0;
         if (in_xfer) begin
            if (!in.tlast) begin
               wr_ptr <= wr_ptr + 1'b1;
            end else if (in_err) begin
               // Forget the whole frame
               wr_ptr <= commit_ptr;
               o_drop <= 1'b1;
            end else begin
               // Completed frame becomes visible to the read side
               wr_ptr     <= wr_ptr + 1'b1;
               commit_ptr <= wr_ptr + 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Read side, limited to committed frames
   ////////////////////////////////////////////////////////////

   assign rd_word    = mem[rd_ptr[AWIDTH-1:0]];
   assign out.tvalid = (rd_ptr != commit_ptr);
   assign out.tdata  = rd_word[DW-1:0];
   assign out.tlast  = rd_word[DW];
   assign out.tuser  = rd_word[MW-1:DW+1];
   assign out_xfer   = out.tvalid && out.tready;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr <= '0;
      end else if (out_xfer) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

//--- verilog/switch_regs.sv
// Switch register block
// Programmed UDP port plus forwarded and dropped frame counters.
// Writing a counter address clears that counter.
`include "eth_params.svh"

module switch_regs (
   input  logic                clk,
   input  logic                reset,
   input  logic                i_reg_wr_req,
   input  eth_pkg::reg_addr_t  i_reg_wr_addr,
   input  eth_pkg::reg_data_t  i_reg_wr_data,
   input  logic                i_reg_rd_req,
   input  eth_pkg::reg_addr_t  i_reg_rd_addr,
   output logic                o_reg_rd_resp,
   output eth_pkg::reg_data_t  o_reg_rd_data,
   input  logic                i_fwd_vita,
   input  logic                i_fwd_cpu,
   input  logic                i_drop,
   output eth_pkg::udp_port_t  o_my_port
);

   eth_pkg::frame_cnt_t cnt_vita;
   eth_pkg::frame_cnt_t cnt_cpu;
   eth_pkg::frame_cnt_t cnt_drop;
   logic                wr_vita;
   logic                wr_cpu;
   logic                wr_drop;

   assign wr_vita = i_reg_wr_req && (i_reg_wr_addr == `REG_CNT_VITA);
   assign wr_cpu  = i_reg_wr_req && (i_reg_wr_addr == `REG_CNT_CPU);
   assign wr_drop = i_reg_wr_req && (i_reg_wr_addr == `REG_CNT_DROP);

   always_ff @(posedge clk) begin
      if (reset) begin
         o_my_port <= `MY_PORT_RESET;
         cnt_vita  <= '0;
         cnt_cpu   <= '0;
         cnt_drop  <= '0;
      end else begin
         if (i_reg_wr_req && (i_reg_wr_addr == `REG_MY_PORT)) begin
            o_my_port <= i_reg_wr_data[15:0];
         end
         // Clear wins over a same-cycle count and the counters wrap
         if (wr_vita) cnt_vita <= '0;
         else if (i_fwd_vita) cnt_vita <= cnt_vita + 1'b1;
         if (wr_cpu) cnt_cpu <= '0;
         else if (i_fwd_cpu) cnt_cpu <= cnt_cpu + 1'b1;
         if (wr_drop) cnt_drop <= '0;
         else if (i_drop) cnt_drop <= cnt_drop + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read path, one cycle latency
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         o_reg_rd_resp <= 1'b0;
      end else begin
         o_reg_rd_resp <= i_reg_rd_req;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reg_rd_req) begin
         case (i_reg_rd_addr)
            `REG_MY_PORT:  o_reg_rd_data <= eth_pkg::reg_data_t'(o_my_port);
            `REG_CNT_VITA: o_reg_rd_data <= eth_pkg::reg_data_t'(cnt_vita);
            `REG_CNT_CPU:  o_reg_rd_data <= eth_pkg::reg_data_t'(cnt_cpu);
            `REG_CNT_DROP: o_reg_rd_data <= eth_pkg::reg_data_t'(cnt_drop);
            default:       o_reg_rd_data <= '0;
         endcase
      end
   end

endmodule
